// ==== verilog/mic_array_pkg.sv ====
package mic_array_pkg;

    //----------------------------------------
    // Widths

    localparam int SAMPLE_W   = 24;  // One microphone sample
    localparam int SUM_W      = 28;  // Seven samples plus a guard bit
    localparam int NORM_SHIFT = 4;   // Low sum bits dropped
    localparam int SLOT_BITS  = 32;  // Serial periods per ws half
    localparam int APB_AW     = 8;
    localparam int APB_DW     = 32;

    typedef logic signed [SAMPLE_W-1:0] mic_sample_t;
    typedef logic signed [SAMPLE_W-1:0] mic_sum_t;   // Normalized sum

    //----------------------------------------
    // Register map

    typedef enum logic [APB_AW-1:0] {
        REG_CTRL   = 8'h00,  // Bit 0 enable
        REG_STATUS = 8'h04,  // Bit 0 new_sum, sticky
        REG_SUM    = 8'h08,
        REG_PEAK   = 8'h0C,
        REG_FRAMES = 8'h10,
        REG_MIC0   = 8'h20,
        REG_MIC1   = 8'h24,
        REG_MIC2   = 8'h28,
        REG_MIC3   = 8'h2C,
        REG_MIC4   = 8'h30,
        REG_MIC5   = 8'h34,
        REG_MIC6   = 8'h38
    } reg_addr_e;

    //----------------------------------------
    // State encodings

    typedef enum logic [1:0] {
        RX_WAIT,
        RX_SHIFT,
        RX_HOLD
    } rx_state_e;

    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_e;

endpackage

// ==== verilog/i2s_clock_gen.sv ====
`timescale 1ns/1ns

module i2s_clock_gen #(
    parameter int SCK_HALF = 2
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_enable,
    output logic       o_sck,
    output logic       o_ws,
    output logic       o_bit_stb,
    output logic [4:0] o_slot_idx,
    output logic       o_frame_end
);

    localparam int PRE_W = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;
    localparam int CNT_W = $clog2(2 * mic_array_pkg::SLOT_BITS);  // Slot plus ws

    logic [PRE_W-1:0] pre_cnt;
    logic [CNT_W-1:0] bit_cnt;
    logic             sck_q;
    logic             half_done;

    assign half_done = (pre_cnt == PRE_W'(SCK_HALF - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre_cnt     <= '0;
            bit_cnt     <= '0;
            sck_q       <= 1'b0;
            o_bit_stb   <= 1'b0;
            o_frame_end <= 1'b0;
        end else if (!i_enable) begin  // Park everything low
            pre_cnt     <= '0;
            bit_cnt     <= '0;
            sck_q       <= 1'b0;
            o_bit_stb   <= 1'b0;
            o_frame_end <= 1'b0;
        end else begin
            o_bit_stb   <= 1'b0;
            o_frame_end <= 1'b0;
            if (half_done) begin
                pre_cnt <= '0;
                sck_q   <= ~sck_q;
                if (!sck_q) begin
                    // Rising edge of sck
                    o_bit_stb   <= 1'b1;
                    o_frame_end <= (bit_cnt == CNT_W'(2 * mic_array_pkg::SLOT_BITS - 1));
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;  // Next slot on falling edge
                end
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

    assign o_sck      = sck_q;
    assign o_ws       = bit_cnt[CNT_W-1];
    assign o_slot_idx = bit_cnt[CNT_W-2:0];

    // Frame end only on the last strobe of the right half
    a_frame_end_on_stb : assert property (
        @(posedge clk) disable iff (rst)
        o_frame_end |-> (o_bit_stb && o_ws && (o_slot_idx == 5'd31))
    );

endmodule

// ==== verilog/i2s_mic_receiver.sv ====
`timescale 1ns/1ns

module i2s_mic_receiver #(
    parameter bit RIGHT_CH = 1'b0
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      i_bit_stb,
    input  logic                      i_ws,
    input  logic [4:0]                i_slot_idx,
    input  logic                      i_sd,
    output mic_array_pkg::mic_sample_t o_sample,
    output logic                      o_sample_vld
);

    localparam int SW = mic_array_pkg::SAMPLE_W;

    mic_array_pkg::rx_state_e   state;
    logic [SW-1:0]              shreg;
    mic_array_pkg::mic_sample_t sample_q;
    logic                       half_match;
    logic                       first_bit;
    logic                       last_bit;
    logic                       shift_en;

    assign half_match = (i_ws == RIGHT_CH);
    assign first_bit  = i_bit_stb && half_match && (i_slot_idx == 5'd1);  // MSB slot
    assign last_bit   = i_bit_stb && (i_slot_idx == 5'(SW));
    assign shift_en   = i_bit_stb && half_match &&
                        ((state == mic_array_pkg::RX_WAIT && first_bit) ||
                         state == mic_array_pkg::RX_SHIFT);

    //----------------------------------------
    // Control FSM

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= mic_array_pkg::RX_WAIT;
        end else begin
            case (state)
                mic_array_pkg::RX_WAIT: begin
                    if (first_bit)
                        state <= mic_array_pkg::RX_SHIFT;
                end
                mic_array_pkg::RX_SHIFT: begin
                    if (!half_match || i_slot_idx == 5'd0)
                        state <= mic_array_pkg::RX_WAIT;  // Clock stopped mid-word
                    else if (last_bit)
                        state <= mic_array_pkg::RX_HOLD;
                end
                mic_array_pkg::RX_HOLD: state <= mic_array_pkg::RX_WAIT;
                default:                state <= mic_array_pkg::RX_WAIT;
            endcase
        end
    end

    //----------------------------------------
    // Datapath

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shreg    <= '0;
            sample_q <= '0;
        end else begin
            if (shift_en)
                shreg <= {shreg[SW-2:0], i_sd};
            if (state == mic_array_pkg::RX_HOLD)
                sample_q <= shreg;
        end
    end

    // Word is forwarded straight from the shifter during the valid cycle
    assign o_sample     = (state == mic_array_pkg::RX_HOLD) ? shreg : sample_q;
    assign o_sample_vld = (state == mic_array_pkg::RX_HOLD);

    a_shift_in_own_half : assert property (
        @(posedge clk) disable iff (rst)
        (i_bit_stb && state == mic_array_pkg::RX_SHIFT) |->
            (half_match && i_slot_idx >= 5'd2 && i_slot_idx <= 5'(SW))
    );

    // Single pulse, and the word stays put once the pulse is over
    a_vld_one_cycle : assert property (
        @(posedge clk) disable iff (rst)
        o_sample_vld |=> (!o_sample_vld && $stable(o_sample))
    );

endmodule

// ==== verilog/mic_sum_normalizer.sv ====
`timescale 1ns/1ns

module mic_sum_normalizer #(
    parameter int N_MICS = 7
) (
    input  logic                       clk,
    input  logic                       rst,
    input  mic_array_pkg::mic_sample_t i_samples [N_MICS],
    input  logic [N_MICS-1:0]          i_sample_vld,
    input  logic                       i_frame_end,
    input  logic                       i_peak_clr,
    output mic_array_pkg::mic_sample_t o_samples [N_MICS],
    output mic_array_pkg::mic_sum_t    o_sum,
    output logic                       o_sum_vld,
    output mic_array_pkg::mic_sum_t    o_peak
);

    localparam int SW = mic_array_pkg::SAMPLE_W;
    localparam mic_array_pkg::mic_sum_t SUM_MIN = {1'b1, {(SW-1){1'b0}}};

    logic signed [mic_array_pkg::SUM_W-1:0] acc;
    mic_array_pkg::mic_sum_t                abs_sum;

    // Hold each microphone's latest word
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < N_MICS; i++)
                o_samples[i] <= '0;
        end else begin
            for (int i = 0; i < N_MICS; i++)
                if (i_sample_vld[i])
                    o_samples[i] <= i_samples[i];
        end
    end

    always_comb begin
        acc = '0;
        for (int i = 0; i < N_MICS; i++)
            acc = acc + o_samples[i];  // Sign-extended add
    end

    always_comb begin
        if (!o_sum[SW-1])
            abs_sum = o_sum;
        else if (o_sum == SUM_MIN)
            abs_sum = ~SUM_MIN;        // Saturate -2^23
        else
            abs_sum = -o_sum;
    end

    //----------------------------------------
    // Sum and peak

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_sum     <= '0;
            o_sum_vld <= 1'b0;
            o_peak    <= '0;
        end else begin
            o_sum_vld <= i_frame_end;
            if (i_frame_end)
                o_sum <= mic_array_pkg::mic_sum_t'(acc >>> mic_array_pkg::NORM_SHIFT);
            if (i_peak_clr)
                o_peak <= '0;
            else if (o_sum_vld && abs_sum > o_peak)
                o_peak <= abs_sum;     // One clock after the sum
        end
    end

endmodule

// ==== verilog/mic_apb_regs.sv ====
`timescale 1ns/1ns

module mic_apb_regs #(
    parameter int N_MICS = 7
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              i_psel,
    input  logic                              i_penable,
    input  logic                              i_pwrite,
    input  logic [mic_array_pkg::APB_AW-1:0]  i_paddr,
    input  logic [mic_array_pkg::APB_DW-1:0]  i_pwdata,
    output logic [mic_array_pkg::APB_DW-1:0]  o_prdata,
    output logic                              o_pready,
    output logic                              o_pslverr,
    input  mic_array_pkg::mic_sample_t        i_samples [N_MICS],
    input  mic_array_pkg::mic_sum_t           i_sum,
    input  logic                              i_sum_vld,
    input  mic_array_pkg::mic_sum_t           i_peak,
    output logic                              o_enable,
    output logic                              o_peak_clr
);

    localparam int DW = mic_array_pkg::APB_DW;
    localparam int SW = mic_array_pkg::SAMPLE_W;

    mic_array_pkg::apb_state_e phase;
    mic_array_pkg::apb_state_e phase_q;  // Phase of the previous cycle
    logic                      access;
    logic                      addr_ok;
    logic [DW-1:0]             rdata;
    logic [2:0]                mic_idx;
    logic                      new_sum;
    logic [DW-1:0]             frame_cnt;
    logic                      rd_sum;

    function automatic logic [DW-1:0] sext(input mic_array_pkg::mic_sample_t v);
        return {{(DW-SW){v[SW-1]}}, v};
    endfunction

    //----------------------------------------
    // Bus phase tracking

    always_comb begin
        if (!i_psel)
            phase = mic_array_pkg::APB_IDLE;
        else if (!i_penable)
            phase = mic_array_pkg::APB_SETUP;
        else
            phase = mic_array_pkg::APB_ACCESS;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            phase_q <= mic_array_pkg::APB_IDLE;
        else
            phase_q <= phase;
    end

    assign access  = (phase == mic_array_pkg::APB_ACCESS);
    assign mic_idx = i_paddr[4:2];  // 0x20 base, word spaced

    //----------------------------------------
    // Address decode and read mux

    always_comb begin
        rdata   = '0;
        addr_ok = 1'b1;
        case (i_paddr)
            mic_array_pkg::REG_CTRL:   rdata = DW'(o_enable);
            mic_array_pkg::REG_STATUS: rdata = DW'(new_sum);
            mic_array_pkg::REG_SUM:    rdata = sext(i_sum);
            mic_array_pkg::REG_PEAK:   rdata = sext(i_peak);
            mic_array_pkg::REG_FRAMES: rdata = frame_cnt;
            mic_array_pkg::REG_MIC0, mic_array_pkg::REG_MIC1,
            mic_array_pkg::REG_MIC2, mic_array_pkg::REG_MIC3,
            mic_array_pkg::REG_MIC4, mic_array_pkg::REG_MIC5,
            mic_array_pkg::REG_MIC6: begin
                if (int'(mic_idx) < N_MICS)
                    rdata = sext(i_samples[mic_idx]);
                else
                    addr_ok = 1'b0;
            end
            default: addr_ok = 1'b0;
        endcase
    end

    assign o_pready   = access;                       // No wait states
    assign o_pslverr  = access && !addr_ok;
    assign o_prdata   = (access && !i_pwrite) ? rdata : '0;
    assign rd_sum     = access && !i_pwrite && (i_paddr == mic_array_pkg::REG_SUM);
    assign o_peak_clr = access && i_pwrite && (i_paddr == mic_array_pkg::REG_PEAK);

    //----------------------------------------
    // Control and status state

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_enable  <= 1'b0;
            new_sum   <= 1'b0;
            frame_cnt <= '0;
        end else begin
            if (access && i_pwrite && i_paddr == mic_array_pkg::REG_CTRL)
                o_enable <= i_pwdata[0];
            if (i_sum_vld)
                new_sum <= 1'b1;   // Set wins over a same-cycle read
            else if (rd_sum)
                new_sum <= 1'b0;
            if (i_sum_vld)
                frame_cnt <= frame_cnt + 1'b1;
        end
    end

    a_enable_after_setup : assert property (
        @(posedge clk) disable iff (rst)
        (phase == mic_array_pkg::APB_ACCESS) |-> (phase_q == mic_array_pkg::APB_SETUP)
    );

endmodule

// ==== verilog/mic_array_top.sv ====
`timescale 1ns/1ns

module mic_array_top #(
    parameter int                N_MICS     = 7,
    parameter int                SCK_HALF   = 2,
    parameter logic [N_MICS-1:0] RIGHT_MASK = 7'b1101010  // 1 selects right slot
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [N_MICS-1:0]                 i_sd,
    output logic                              o_sck,
    output logic                              o_ws,
    input  logic                              i_psel,
    input  logic                              i_penable,
    input  logic                              i_pwrite,
    input  logic [mic_array_pkg::APB_AW-1:0]  i_paddr,
    input  logic [mic_array_pkg::APB_DW-1:0]  i_pwdata,
    output logic [mic_array_pkg::APB_DW-1:0]  o_prdata,
    output logic                              o_pready,
    output logic                              o_pslverr
);

    logic                       enable;
    logic                       bit_stb;
    logic [4:0]                 slot_idx;
    logic                       frame_end;
    mic_array_pkg::mic_sample_t sample     [N_MICS];
    logic [N_MICS-1:0]          sample_vld;
    mic_array_pkg::mic_sample_t lat_sample [N_MICS];  // Combiner copies for readback
    mic_array_pkg::mic_sum_t    sum;
    logic                       sum_vld;
    mic_array_pkg::mic_sum_t    peak;
    logic                       peak_clr;

    //----------------------------------------
    // Shared serial clock and word select

    i2s_clock_gen #(
        .SCK_HALF    (SCK_HALF)
    ) u_clk_gen (
        .clk         (clk),
        .rst         (rst),
        .i_enable    (enable),
        .o_sck       (o_sck),
        .o_ws        (o_ws),
        .o_bit_stb   (bit_stb),
        .o_slot_idx  (slot_idx),
        .o_frame_end (frame_end)
    );

    // One receiver per microphone line
    for (genvar g = 0; g < N_MICS; g++) begin : g_rx
        i2s_mic_receiver #(
            .RIGHT_CH     (RIGHT_MASK[g])
        ) u_rx (
            .clk          (clk),
            .rst          (rst),
            .i_bit_stb    (bit_stb),
            .i_ws         (o_ws),
            .i_slot_idx   (slot_idx),
            .i_sd         (i_sd[g]),
            .o_sample     (sample[g]),
            .o_sample_vld (sample_vld[g])
        );
    end

    mic_sum_normalizer #(
        .N_MICS       (N_MICS)
    ) u_sum (
        .clk          (clk),
        .rst          (rst),
        .i_samples    (sample),
        .i_sample_vld (sample_vld),
        .i_frame_end  (frame_end),
        .i_peak_clr   (peak_clr),
        .o_samples    (lat_sample),
        .o_sum        (sum),
        .o_sum_vld    (sum_vld),
        .o_peak       (peak)
    );

    mic_apb_regs #(
        .N_MICS     (N_MICS)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .i_samples  (lat_sample),
        .i_sum      (sum),
        .i_sum_vld  (sum_vld),
        .i_peak     (peak),
        .o_enable   (enable),
        .o_peak_clr (peak_clr)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Reset released on a rising edge
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// ==== tb/mic_array_tb.sv ====
`timescale 1ns/1ns

// Serial microphone model that shifts out one bit per falling sck edge
module i2s_mic_model #(
    parameter bit RIGHT_CH = 1'b0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_sck,
    input  logic        i_ws,
    input  logic [23:0] i_word,
    output logic        o_sd
);

    logic        sd_q   = 1'b0;
    logic        sck_q  = 1'b0;
    logic        ws_q   = 1'b0;
    int          slot   = 0;
    logic [23:0] word_q = '0;

    always @(posedge clk) begin : drive_bits
        int          nslot;
        logic [23:0] nword;
        if (rst) begin
            sd_q   <= 1'b0;
            sck_q  <= 1'b0;
            ws_q   <= 1'b0;
            slot   <= 0;
            word_q <= '0;
        end else begin
            sck_q <= i_sck;
            if (sck_q && !i_sck) begin
                nslot = (i_ws != ws_q) ? 0 : slot + 1;  // ws edge restarts the count
                // New word taken only at the start of a frame
                nword = (!i_ws && nslot == 1) ? i_word : word_q;
                slot   <= nslot;
                ws_q   <= i_ws;
                word_q <= nword;
                if (i_ws == RIGHT_CH && nslot >= 1 && nslot <= 24)
                    sd_q <= nword[24 - nslot];
                else
                    sd_q <= 1'b0;
            end
        end
    end

    assign o_sd = sd_q;

endmodule

module mic_array_tb;

    localparam int          N_ROWS       = 6;
    localparam int          PEAK_CLR_ROW = 4;
    localparam logic [6:0]  RIGHT_MASK   = 7'b1101010;

    logic        clk;
    logic        rst;
    logic [6:0]  sd;
    logic        sck;
    logic        ws;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [23:0]                mic_word [7];
    mic_array_pkg::mic_sample_t stim [N_ROWS][7];
    mic_array_pkg::mic_sum_t    peak_exp;
    int unsigned                last_frames;
    int                         cycles = 0;
    int                         errors = 0;
    int                         tests  = 0;
    int                         failed = 0;
    int                         test_err0;
    string                      test_name;

    tb_clock_gen u_clk (.o_clk(clk), .o_rst(rst));

    mic_array_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .i_sd      (sd),
        .o_sck     (sck),
        .o_ws      (ws),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    for (genvar g = 0; g < 7; g++) begin : g_mic
        i2s_mic_model #(.RIGHT_CH(RIGHT_MASK[g])) u_mic (
            .clk    (clk),
            .rst    (rst),
            .i_sck  (sck),
            .i_ws   (ws),
            .i_word (mic_word[g]),
            .o_sd   (sd[g])
        );
    end

    always @(posedge clk) cycles <= cycles + 1;

    //----------------------------------------
    // Reporting and compare tasks

    task automatic abort_run(input string why);
        $display("timeout: %s at %0t", why, $time);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
        tests++;
    endtask

    task automatic end_test();
        if (errors == test_err0) begin
            $display("%s pass", test_name);
        end else begin
            $display("%s fail, %0d errors", test_name, errors - test_err0);
            failed++;
        end
    endtask

    task automatic check_sample(input string name, input mic_array_pkg::mic_sample_t got,
                                input mic_array_pkg::mic_sample_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %06h expected %06h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_sum(input string name, input mic_array_pkg::mic_sum_t got,
                             input mic_array_pkg::mic_sum_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %06h expected %06h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %08h expected %08h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_sext(input string name, input logic [31:0] data,
                              input logic sign);
        if (data[31:24] !== {8{sign}}) begin
            $display("mismatch at %0t: %s[31:24] got %02h expected %02h", $time, name,
                     data[31:24], {8{sign}});
            errors++;
        end
    endtask

    //----------------------------------------
    // APB master

    task automatic apb_access(input logic [7:0] addr, input logic write,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err, output logic rdy);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        rdata = prdata;       // Sampled at the end of the access cycle
        err   = pslverr;
        rdy   = pready;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        logic rdy;
        apb_access(addr, 1'b0, 32'h0, data, err, rdy);
        if (err) begin
            $display("unexpected slave error reading address %02h at %0t", addr, $time);
            errors++;
        end
        if (!rdy) begin
            $display("o_pready low in the access cycle reading address %02h at %0t",
                     addr, $time);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] unused;
        logic        err;
        logic        rdy;
        apb_access(addr, 1'b1, data, unused, err, rdy);
        if (err) begin
            $display("unexpected slave error writing address %02h at %0t", addr, $time);
            errors++;
        end
        if (!rdy) begin
            $display("o_pready low in the access cycle writing address %02h at %0t",
                     addr, $time);
            errors++;
        end
    endtask

    task automatic wait_new_sum();
        logic [31:0] data;
        int          start;
        start = cycles;
        data  = '0;
        while (!data[0]) begin
            if (cycles - start > 1000)
                abort_run("new_sum not set within 1000 cycles");
            read_reg(mic_array_pkg::REG_STATUS, data);
        end
    endtask

    //----------------------------------------
    // Expected values

    function automatic mic_array_pkg::mic_sum_t expected_sum(input int r);
        int total;
        total = 0;
        for (int m = 0; m < 7; m++)
            total += int'(stim[r][m]);
        return mic_array_pkg::mic_sum_t'(total >>> 4);
    endfunction

    function automatic mic_array_pkg::mic_sum_t magnitude(input mic_array_pkg::mic_sum_t v);
        if (v >= 0)
            return v;
        if (v == 24'sh800000)
            return 24'sh7FFFFF;   // No positive twin for -2^23
        return -v;
    endfunction

    task automatic fill_stimulus();
        void'($urandom(32'h4932));
        for (int m = 0; m < 7; m++) begin
            stim[0][m] = 24'h7FFFFF;   // Full scale positive
            stim[1][m] = 24'h800000;   // Full scale negative
        end
        stim[2] = '{24'h000001, 24'hFFFFFF, 24'h123456, 24'hEDCBAA,
                    24'h7FFFFF, 24'h800000, 24'h0ABCDE};
        stim[3] = '{24'h7FFFFF, 24'h800000, 24'h7FFFFF, 24'h800000,
                    24'h400000, 24'hC00001, 24'h000010};
        for (int r = 4; r < N_ROWS; r++)
            for (int m = 0; m < 7; m++)
                stim[r][m] = mic_array_pkg::mic_sample_t'($urandom());
    endtask

    task automatic run_row(input int r);
        logic [31:0]             data;
        mic_array_pkg::mic_sum_t exp_sum;
        mic_array_pkg::mic_sum_t mag;
        exp_sum = expected_sum(r);
        mag     = magnitude(exp_sum);
        @(posedge clk);
        for (int m = 0; m < 7; m++)
            mic_word[m] <= stim[r][m];
        read_reg(mic_array_pkg::REG_SUM, data);  // Clear new_sum
        wait_new_sum();                          // May still carry the old words
        if (r == PEAK_CLR_ROW) begin
            write_reg(mic_array_pkg::REG_PEAK, 32'h0);
            peak_exp = '0;
        end
        read_reg(mic_array_pkg::REG_SUM, data);
        wait_new_sum();
        for (int m = 0; m < 7; m++) begin
            read_reg(8'h20 + 8'(4 * m), data);
            check_sample($sformatf("REG_MIC%0d", m), data[23:0], stim[r][m]);
            check_sext($sformatf("REG_MIC%0d", m), data, stim[r][m][23]);
        end
        read_reg(mic_array_pkg::REG_SUM, data);
        check_sum("REG_SUM", data[23:0], exp_sum);
        check_sext("REG_SUM", data, exp_sum[23]);
        read_reg(mic_array_pkg::REG_STATUS, data);
        check_word("REG_STATUS", data, 32'h0);   // Cleared by the sum read
        if (mag > peak_exp)
            peak_exp = mag;
        read_reg(mic_array_pkg::REG_PEAK, data);
        check_sum("REG_PEAK", data[23:0], peak_exp);
        check_sext("REG_PEAK", data, peak_exp[23]);
        read_reg(mic_array_pkg::REG_FRAMES, data);
        if (data < last_frames || int'(data) < r + 1) begin
            $display("REG_FRAMES is %0d after row %0d, last read %0d", data, r, last_frames);
            errors++;
        end
        last_frames = data;
    endtask

    //----------------------------------------
    // Test sequence

    initial begin : main
        logic [31:0] data;
        logic [31:0] frames0;
        logic        err;
        logic        rdy;
        int          n;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        peak_exp = '0;
        for (int m = 0; m < 7; m++)
            mic_word[m] = '0;
        fill_stimulus();

        n = 0;
        while (rst && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (rst)
            abort_run("reset never released");

        start_test("reset");
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            check_word("o_sck", {31'b0, sck}, 32'h0);
            check_word("o_ws", {31'b0, ws}, 32'h0);
        end
        read_reg(mic_array_pkg::REG_CTRL, data);
        check_word("REG_CTRL", data, 32'h0);
        read_reg(mic_array_pkg::REG_STATUS, data);
        check_word("REG_STATUS", data, 32'h0);
        read_reg(mic_array_pkg::REG_FRAMES, data);
        check_word("REG_FRAMES", data, 32'h0);
        last_frames = data;
        end_test();

        write_reg(mic_array_pkg::REG_CTRL, 32'h1);
        for (int r = 0; r < N_ROWS; r++) begin
            start_test($sformatf("row %0d", r));
            run_row(r);
            end_test();
        end

        start_test("disable");
        write_reg(mic_array_pkg::REG_CTRL, 32'h0);
        repeat (2) @(posedge clk);               // Clock generator parks
        read_reg(mic_array_pkg::REG_FRAMES, frames0);
        n = 0;
        for (int i = 0; i < 500; i++) begin
            @(posedge clk);
            if (sck)
                n++;
        end
        if (n != 0) begin
            $display("o_sck was high for %0d cycles after disable", n);
            errors++;
        end
        read_reg(mic_array_pkg::REG_FRAMES, data);
        check_word("REG_FRAMES", data, frames0);
        read_reg(mic_array_pkg::REG_CTRL, data);
        check_word("REG_CTRL", data, 32'h0);
        end_test();

        start_test("bus err");
        apb_access(8'h40, 1'b0, 32'h0, data, err, rdy);  // Unmapped
        check_word("o_pslverr", {31'b0, err}, 32'h1);
        check_word("o_pready", {31'b0, rdy}, 32'h1);
        end_test();

        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/mic_array_pkg.sv
verilog/i2s_clock_gen.sv
verilog/i2s_mic_receiver.sv
verilog/mic_sum_normalizer.sv
verilog/mic_apb_regs.sv
verilog/mic_array_top.sv
tb/tb_clock_gen.sv
tb/mic_array_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module mic_array_tb \
    -f flist.f \
    -o mic_array_sim

./obj_dir/mic_array_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^NO ERRORS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
